/* rtl/mesh_pkg.sv */
/*
 * Shared sizes, step timing, memory map and packet formats for the
 * mesh spike-traffic controller. Every RTL block imports what it needs.
 */
package mesh_pkg;

    // ----------------------------------------
    // sizes
    // ----------------------------------------
    localparam int addr_width = 8;
    localparam int word_width = 32;
    localparam int mem_depth  = 2 ** addr_width;

    // ----------------------------------------
    // step timing
    // ----------------------------------------
    localparam int step_number = 4;
    // minimum neu_clk cycles from one step_start to the next
    localparam int step_cycles = 64;
    // idle cycles after each spike so the boundary router fifo never fills
    localparam int send_gap    = 4;

    // counter widths, one spare bit so the terminal count fits
    localparam int step_cnt_width  = $clog2(step_number) + 1;
    localparam int cycle_cnt_width = $clog2(step_cycles) + 1;
    localparam int gap_cnt_width   = $clog2(send_gap) + 1;

    // schedule lives below result_base, results from result_base up
    localparam int result_base = 128;

    // arbiter slots, also the order of the rotating priority
    localparam logic [1:0] cl_host = 2'd0;
    localparam logic [1:0] cl_coll = 2'd1;
    localparam logic [1:0] cl_inj  = 2'd2;

    typedef logic [word_width-1:0] word_t;

    // spike packet as injected into the router local port
    typedef struct packed {
        logic        kind;
        logic [2:0]  dest_x;
        logic [2:0]  dest_y;
        logic [7:0]  neuron_id;
        logic [16:0] weight;
    } spike_pkt_t;

    // step header, leads each step's spikes in the schedule
    typedef struct packed {
        logic        kind;
        logic [7:0]  packet_count;
        logic [22:0] reserved;
    } step_hdr_t;

    // a schedule word is either a header or a spike, told apart by kind
    typedef union packed {
        spike_pkt_t spike;
        step_hdr_t  hdr;
    } mem_word_u;

    typedef struct packed {
        logic                  we;
        logic [addr_width-1:0] addr;
        word_t                 wdata;
    } mem_req_t;

    typedef struct packed {
        logic  rvalid;
        word_t rdata;
    } mem_rsp_t;

endpackage

/* rtl/packet_mem.sv */
/*
 * Single-port packet memory shared by host, injector and collector.
 * Holds the step schedule and the result region; one-cycle read latency.
 */
`timescale 1ns/1ps

module packet_mem (
    input  logic               neu_clk,
    input  mesh_pkg::mem_req_t req,
    input  logic               req_en,
    output mesh_pkg::word_t    rdata
);
    import mesh_pkg::*;

    word_t mem [mem_depth];

    // write port
    always_ff @(posedge neu_clk)
    begin
        if (req_en && req.we)
            mem[req.addr] <= req.wdata;
    end

    // registered read, data shows up the cycle after the request is taken
    always_ff @(posedge neu_clk)
    begin
        if (req_en && !req.we)
            rdata <= mem[req.addr];
    end

endmodule

/* rtl/mem_arbiter.sv */
/*
 * Round-robin arbiter for the three packet memory clients.
 * Grant is combinational; read data returns one cycle later to the winner only.
 */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic               neu_clk,
    input  logic               rst_n,
    input  mesh_pkg::mem_req_t host_req,
    input  logic               host_valid,
    input  mesh_pkg::mem_req_t coll_req,
    input  logic               coll_valid,
    input  mesh_pkg::mem_req_t inj_req,
    input  logic               inj_valid,
    output logic               host_ready,
    output logic               coll_ready,
    output logic               inj_ready,
    output mesh_pkg::mem_rsp_t host_rsp,
    output mesh_pkg::mem_rsp_t coll_rsp,
    output mesh_pkg::mem_rsp_t inj_rsp,
    output mesh_pkg::mem_req_t mem_req,
    output logic               mem_en,
    input  mesh_pkg::word_t    mem_rdata
);
    import mesh_pkg::*;

    mem_req_t   req_arr [3];
    logic [2:0] valid_vec;
    logic [2:0] grant;
    logic [1:0] last;
    logic [1:0] win;
    logic [1:0] cand;
    logic       found;
    // winner of the previous cycle and whether it was a read
    logic [1:0] rsp_sel;
    logic       rsp_rd;

    assign req_arr[cl_host] = host_req;
    assign req_arr[cl_coll] = coll_req;
    assign req_arr[cl_inj]  = inj_req;
    assign valid_vec = {inj_valid, coll_valid, host_valid};

    // ----------------------------------------
    // rotating priority, search starts just after the last winner
    // ----------------------------------------
    always_comb
    begin
        grant = '0;
        win   = last;
        found = 1'b0;
        cand  = last;
        for (int k = 1; k <= 3; k++)
        begin
            cand = 2'((int'(last) + k) % 3);
            if (!found && valid_vec[cand])
            begin
                grant[cand] = 1'b1;
                win         = cand;
                found       = 1'b1;
            end
        end
    end

    assign host_ready = grant[cl_host];
    assign coll_ready = grant[cl_coll];
    assign inj_ready  = grant[cl_inj];
    assign mem_req    = req_arr[win];
    assign mem_en     = found;

    always_ff @(posedge neu_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            // host sees top priority first
            last    <= cl_inj;
            rsp_sel <= cl_host;
            rsp_rd  <= 1'b0;
        end
        else
        begin
            rsp_rd <= found && !mem_req.we;
            if (found)
            begin
                last    <= win;
                rsp_sel <= win;
            end
        end
    end

    // ----------------------------------------
    // read data back to the registered winner
    // ----------------------------------------
    assign host_rsp.rvalid = rsp_rd && (rsp_sel == cl_host);
    assign host_rsp.rdata  = mem_rdata;
    assign coll_rsp.rvalid = rsp_rd && (rsp_sel == cl_coll);
    assign coll_rsp.rdata  = mem_rdata;
    assign inj_rsp.rvalid  = rsp_rd && (rsp_sel == cl_inj);
    assign inj_rsp.rdata   = mem_rdata;

    // a requester left waiting keeps its valid up until it is granted
    assert property (@(posedge neu_clk) disable iff (!rst_n)
        ((valid_vec & ~grant) != 3'b000) |=>
            ((valid_vec & $past(valid_vec & ~grant)) == $past(valid_vec & ~grant)))
        else $error("mem_arbiter: request withdrawn before grant, valid %b", valid_vec);

endmodule

/* rtl/spike_injector.sv */
/*
 * Replays the step schedule after a run pulse. Each step pulses step_start,
 * fetches the step header, then fetches and offers each spike with a gap.
 */
`timescale 1ns/1ps

module spike_injector (
    input  logic                 neu_clk,
    input  logic                 rst_n,
    input  logic                 run,
    output mesh_pkg::mem_req_t   mem_req,
    output logic                 req_valid,
    input  logic                 req_ready,
    input  mesh_pkg::mem_rsp_t   rsp,
    output mesh_pkg::spike_pkt_t spike_out,
    output logic                 spike_valid,
    input  logic                 spike_ready,
    output logic                 step_start,
    output logic                 run_done
);
    import mesh_pkg::*;

    typedef enum logic [2:0] {
        s_idle,
        s_hdr,
        s_fetch,
        s_offer,
        s_gap,
        s_wait
    } state_t;

    state_t                     state;
    logic [addr_width-1:0]      ptr;
    logic [step_cnt_width-1:0]  step_cnt;
    logic [7:0]                 pkt_left;
    logic [gap_cnt_width-1:0]   gap_cnt;
    logic [cycle_cnt_width-1:0] cycle_cnt;
    // read granted, data not back yet
    logic                       pending;
    logic                       boundary;
    logic                       last_step;
    mem_word_u                  fetched;
    spike_pkt_t                 spike_reg;

    assign fetched = rsp.rdata;

    // cycle counter saturates, so boundary stays up once reached
    assign boundary  = (cycle_cnt == cycle_cnt_width'(step_cycles - 1));
    assign last_step = (step_cnt == step_cnt_width'(step_number - 1));

    // step_start on leaving either wait state
    assign step_start = (state == s_idle && run) ||
                        (state == s_wait && !last_step && boundary);

    // reads only, schedule walks up from address 0
    assign mem_req   = '{we: 1'b0, addr: ptr, wdata: '0};
    assign req_valid = (state == s_hdr || state == s_fetch) && !pending;

    assign spike_out   = spike_reg;
    assign spike_valid = (state == s_offer);

    always_ff @(posedge neu_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= s_idle;
            ptr       <= '0;
            step_cnt  <= '0;
            pkt_left  <= '0;
            gap_cnt   <= '0;
            cycle_cnt <= '0;
            pending   <= 1'b0;
            run_done  <= 1'b0;
        end
        else
        begin
            // ----------------------------------------
            // step timer and outstanding read
            // ----------------------------------------
            if (step_start)
                cycle_cnt <= '0;
            else if (!boundary)
                cycle_cnt <= cycle_cnt + 1'b1;

            if (req_valid && req_ready)
                pending <= 1'b1;
            else if (rsp.rvalid)
                pending <= 1'b0;

            // pointer moves as soon as a fetch is granted
            if (req_valid && req_ready)
                ptr <= ptr + 1'b1;

            case (state)
                s_idle:
                begin
                    if (run)
                    begin
                        run_done <= 1'b0;
                        ptr      <= '0;
                        step_cnt <= '0;
                        state    <= s_hdr;
                    end
                end
                s_hdr:
                begin
                    // an empty step goes straight to the boundary wait
                    if (rsp.rvalid)
                    begin
                        pkt_left <= fetched.hdr.packet_count;
                        if (fetched.hdr.packet_count == 8'd0)
                            state <= s_wait;
                        else
                            state <= s_fetch;
                    end
                end
                s_fetch:
                begin
                    if (rsp.rvalid)
                        state <= s_offer;
                end
                s_offer:
                begin
                    // held until the router takes it
                    if (spike_ready)
                    begin
                        pkt_left <= pkt_left - 1'b1;
                        gap_cnt  <= '0;
                        state    <= s_gap;
                    end
                end
                s_gap:
                begin
                    if (gap_cnt == gap_cnt_width'(send_gap - 1))
                        state <= (pkt_left == 8'd0) ? s_wait : s_fetch;
                    else
                        gap_cnt <= gap_cnt + 1'b1;
                end
                s_wait:
                begin
                    if (last_step)
                    begin
                        run_done <= 1'b1;
                        state    <= s_idle;
                    end
                    else if (boundary)
                    begin
                        step_cnt <= step_cnt + 1'b1;
                        state    <= s_hdr;
                    end
                end
                default:
                    state <= s_idle;
            endcase
        end
    end

    // spike payload
    always_ff @(posedge neu_clk)
    begin
        if (state == s_fetch && rsp.rvalid)
            spike_reg <= fetched.spike;
    end

    // schedule contents loaded by the host must line up with the counts
    assert property (@(posedge neu_clk) disable iff (!rst_n)
        (rsp.rvalid && state == s_hdr) |-> !fetched.hdr.kind)
        else $error("spike_injector: expected header, got spike word");
    assert property (@(posedge neu_clk) disable iff (!rst_n)
        (rsp.rvalid && state == s_fetch) |-> fetched.spike.kind)
        else $error("spike_injector: expected spike, got header word");

endmodule

/* rtl/result_collector.sv */
/*
 * Takes result packets from the router local port and writes them to the
 * result region in arrival order. One packet is buffered at a time.
 */
`timescale 1ns/1ps

module result_collector (
    input  logic                            neu_clk,
    input  logic                            rst_n,
    input  logic                            run,
    input  mesh_pkg::word_t                 result_in,
    input  logic                            result_valid,
    output logic                            result_ready,
    output mesh_pkg::mem_req_t              mem_req,
    output logic                            req_valid,
    input  logic                            req_ready,
    output logic [mesh_pkg::addr_width-1:0] result_count
);
    import mesh_pkg::*;

    word_t hold_data;
    logic  full;
    logic  take;
    logic  write_done;

    assign take       = result_valid && result_ready;
    assign write_done = req_valid && req_ready;

    // buffered word goes to the next free slot of the result region
    assign req_valid = full;
    assign mem_req   = '{we: 1'b1,
                         addr: addr_width'(result_base) + result_count,
                         wdata: hold_data};

    always_ff @(posedge neu_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            full         <= 1'b0;
            result_ready <= 1'b0;
            result_count <= '0;
        end
        else
        begin
            // ready drops for as long as a write is outstanding
            if (take)
            begin
                full         <= 1'b1;
                result_ready <= 1'b0;
            end
            else if (write_done)
            begin
                full         <= 1'b0;
                result_ready <= 1'b1;
            end
            else
                result_ready <= !full;

            if (run)
                result_count <= '0;
            else if (write_done)
                result_count <= result_count + 1'b1;
        end
    end

    always_ff @(posedge neu_clk)
    begin
        if (take)
            hold_data <= result_in;
    end

    assert property (@(posedge neu_clk) disable iff (!rst_n)
        write_done |-> (int'(result_count) < mem_depth - result_base))
        else $error("result_collector: result region overflow");

endmodule

/* rtl/mesh_controller.sv */
/*
 * Spike-traffic controller for one router local port. Ties the host port,
 * the injector and the collector to the shared packet memory.
 */
`timescale 1ns/1ps

module mesh_controller (
    input  logic                            neu_clk,
    input  logic                            rst_n,
    input  logic                            run,
    input  mesh_pkg::mem_req_t              host_req,
    input  logic                            host_valid,
    output logic                            host_ready,
    output mesh_pkg::mem_rsp_t              host_rsp,
    output mesh_pkg::spike_pkt_t            spike_out,
    output logic                            spike_valid,
    input  logic                            spike_ready,
    input  mesh_pkg::word_t                 result_in,
    input  logic                            result_valid,
    output logic                            result_ready,
    output logic                            step_start,
    output logic                            run_done,
    output logic [mesh_pkg::addr_width-1:0] result_count
);
    import mesh_pkg::*;

    mem_req_t coll_req;
    logic     coll_valid;
    logic     coll_ready;
    mem_req_t inj_req;
    logic     inj_valid;
    logic     inj_ready;
    mem_rsp_t inj_rsp;
    mem_req_t mem_req;
    logic     mem_en;
    word_t    mem_rdata;

    // ----------------------------------------
    // shared memory and its arbiter
    // ----------------------------------------
    // collector only writes, its response slot stays open
    mem_arbiter arb0 (
        .neu_clk   (neu_clk),
        .rst_n     (rst_n),
        .host_req  (host_req),
        .host_valid(host_valid),
        .coll_req  (coll_req),
        .coll_valid(coll_valid),
        .inj_req   (inj_req),
        .inj_valid (inj_valid),
        .host_ready(host_ready),
        .coll_ready(coll_ready),
        .inj_ready (inj_ready),
        .host_rsp  (host_rsp),
        .coll_rsp  (),
        .inj_rsp   (inj_rsp),
        .mem_req   (mem_req),
        .mem_en    (mem_en),
        .mem_rdata (mem_rdata)
    );

    packet_mem mem0 (
        .neu_clk(neu_clk),
        .req    (mem_req),
        .req_en (mem_en),
        .rdata  (mem_rdata)
    );

    // ----------------------------------------
    // router side engines
    // ----------------------------------------
    spike_injector inj0 (
        .neu_clk    (neu_clk),
        .rst_n      (rst_n),
        .run        (run),
        .mem_req    (inj_req),
        .req_valid  (inj_valid),
        .req_ready  (inj_ready),
        .rsp        (inj_rsp),
        .spike_out  (spike_out),
        .spike_valid(spike_valid),
        .spike_ready(spike_ready),
        .step_start (step_start),
        .run_done   (run_done)
    );

    result_collector coll0 (
        .neu_clk     (neu_clk),
        .rst_n       (rst_n),
        .run         (run),
        .result_in   (result_in),
        .result_valid(result_valid),
        .result_ready(result_ready),
        .mem_req     (coll_req),
        .req_valid   (coll_valid),
        .req_ready   (coll_ready),
        .result_count(result_count)
    );

endmodule

/* sim/tb_mesh_controller.sv */
/*
 * Testbench for the mesh spike-traffic controller. Loads a step schedule over
 * the host port, runs it twice against a spike sink and a result source, and
 * checks spike order, step timing and the stored results.
 */
`timescale 1ns/1ps

module tb_mesh_controller;
    import mesh_pkg::*;

    // handshake and run bounds, in neu_clk cycles
    localparam int wait_limit    = 200;
    localparam int run_limit     = 5000;
    localparam int result_number = 6;

    logic                  neu_clk = 1'b0;
    logic                  rst_n;
    logic                  run;
    mem_req_t              host_req;
    logic                  host_valid;
    logic                  host_ready;
    mem_rsp_t              host_rsp;
    spike_pkt_t            spike_out;
    logic                  spike_valid;
    logic                  spike_ready;
    word_t                 result_in;
    logic                  result_valid;
    logic                  result_ready;
    logic                  step_start;
    logic                  run_done;
    logic [addr_width-1:0] result_count;

    integer seed = 32'h2998;

    // ----------------------------------------
    // stimulus and expected tables
    // ----------------------------------------
    // packets per step, step 1 is empty
    int         step_len [step_number] = '{3, 0, 2, 4};
    spike_pkt_t spike_tab [$];
    int         spike_step [$];
    word_t      sched_img [$];
    word_t      result_tab [$];

    // what the spike sink saw, across both runs
    spike_pkt_t got_spike [$];
    int         got_step [$];
    int         step_seen = 0;

    mesh_controller dut0 (
        .neu_clk     (neu_clk),
        .rst_n       (rst_n),
        .run         (run),
        .host_req    (host_req),
        .host_valid  (host_valid),
        .host_ready  (host_ready),
        .host_rsp    (host_rsp),
        .spike_out   (spike_out),
        .spike_valid (spike_valid),
        .spike_ready (spike_ready),
        .result_in   (result_in),
        .result_valid(result_valid),
        .result_ready(result_ready),
        .step_start  (step_start),
        .run_done    (run_done),
        .result_count(result_count)
    );

    always #50 neu_clk = ~neu_clk;

    // ----------------------------------------
    // reporting and compare tasks
    // ----------------------------------------
    task automatic halt_sim();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_spike(input string name, input spike_pkt_t exp,
                               input spike_pkt_t act);
        if (act !== exp)
        begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            halt_sim();
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
        begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            halt_sim();
        end
    endtask

    task automatic check_count(input string name, input logic [addr_width-1:0] exp,
                               input logic [addr_width-1:0] act);
        if (act !== exp)
        begin
            $display("[ERROR] %s expected %0d actual %0d", name, exp, act);
            halt_sim();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("[ERROR] %s expected %b actual %b", name, exp, act);
            halt_sim();
        end
    endtask

    // header word, then its spikes, step after step from address 0
    task automatic build_tables();
        spike_pkt_t sp;
        step_hdr_t  hd;
        for (int s = 0; s < step_number; s++)
        begin
            hd = '{kind: 1'b0, packet_count: 8'(step_len[s]), reserved: '0};
            sched_img.push_back(word_t'(hd));
            for (int p = 0; p < step_len[s]; p++)
            begin
                sp.kind      = 1'b1;
                sp.dest_x    = 3'(spike_tab.size());
                sp.dest_y    = 3'(s + p);
                sp.neuron_id = 8'(16 * s + p + 1);
                sp.weight    = 17'($random(seed));
                spike_tab.push_back(sp);
                spike_step.push_back(s);
                sched_img.push_back(word_t'(sp));
            end
        end
    endtask

    // ----------------------------------------
    // host port
    // ----------------------------------------
    // request held until granted, grant seen at negedge, taken at next posedge
    task automatic host_access(input mem_req_t r);
        int n;
        n = 0;
        @(posedge neu_clk);
        host_req   <= r;
        host_valid <= 1'b1;
        @(negedge neu_clk);
        while (!host_ready && n < wait_limit)
        begin
            @(negedge neu_clk);
            n++;
        end
        if (!host_ready)
        begin
            $display("timeout: host request to address %0d was never granted", r.addr);
            halt_sim();
        end
        @(posedge neu_clk);
        host_valid <= 1'b0;
    endtask

    task automatic host_write(input logic [addr_width-1:0] a, input word_t d);
        host_access(mem_req_t'{we: 1'b1, addr: a, wdata: d});
    endtask

    task automatic host_read(input logic [addr_width-1:0] a, output word_t d);
        int n;
        host_access(mem_req_t'{we: 1'b0, addr: a, wdata: '0});
        n = 0;
        @(negedge neu_clk);
        while (!host_rsp.rvalid && n < wait_limit)
        begin
            @(negedge neu_clk);
            n++;
        end
        if (!host_rsp.rvalid)
        begin
            $display("timeout: no read data for host address %0d", a);
            halt_sim();
        end
        d = host_rsp.rdata;
    endtask

    // reads the schedule back while the injector and collector are busy
    task automatic host_contention(input int pass);
        word_t d;
        for (int i = 0; i < sched_img.size(); i += 3)
        begin
            repeat ($random(seed) & 3) @(posedge neu_clk);
            host_read(addr_width'(i), d);
            check_word($sformatf("pass %0d schedule word %0d during run", pass, i),
                       sched_img[i], d);
        end
    endtask

    // ----------------------------------------
    // router models
    // ----------------------------------------
    task automatic send_result(input word_t w);
        int n;
        n = 0;
        @(posedge neu_clk);
        result_in    <= w;
        result_valid <= 1'b1;
        @(negedge neu_clk);
        while (!result_ready && n < wait_limit)
        begin
            @(negedge neu_clk);
            n++;
        end
        if (!result_ready)
        begin
            $display("timeout: result word %h was never accepted", w);
            halt_sim();
        end
        @(posedge neu_clk);
        result_valid <= 1'b0;
    endtask

    task automatic send_results();
        for (int r = 0; r < result_number; r++)
        begin
            repeat ($random(seed) & 15) @(posedge neu_clk);
            send_result(result_tab[r]);
        end
    endtask

    // spike sink drops ready about one cycle in four
    initial
    begin
        spike_ready = 1'b0;
        forever
        begin
            @(posedge neu_clk);
            if (!rst_n)
                spike_ready <= 1'b0;
            else
                spike_ready <= (($random(seed) & 3) != 0);
        end
    end

    // a transfer seen at negedge completes on the next rising edge
    initial
    begin
        forever
        begin
            @(negedge neu_clk);
            if (rst_n)
            begin
                if (step_start)
                    step_seen = step_seen + 1;
                if (spike_valid && spike_ready)
                begin
                    got_spike.push_back(spike_out);
                    got_step.push_back(step_seen - 1);
                end
            end
        end
    end

    // ----------------------------------------
    // run control
    // ----------------------------------------
    task automatic pulse_run();
        @(posedge neu_clk);
        run <= 1'b1;
        @(posedge neu_clk);
        run <= 1'b0;
    endtask

    task automatic wait_run_done(input int pass, input int spike_base, input int step_base);
        int n;
        n = 0;
        @(negedge neu_clk);
        while (!run_done && n < run_limit)
        begin
            @(negedge neu_clk);
            n++;
        end
        if (!run_done)
        begin
            $display("timeout: run_done never rose in pass %0d", pass);
            halt_sim();
        end
        // every spike and step pulse is in by the time run_done rises
        check_count($sformatf("pass %0d spikes before run_done", pass),
                    addr_width'(spike_tab.size()), addr_width'(got_spike.size() - spike_base));
        check_count($sformatf("pass %0d step_start pulses", pass),
                    addr_width'(step_number), addr_width'(step_seen - step_base));
    endtask

    task automatic run_pass(input int pass);
        int    spike_base;
        int    step_base;
        int    n;
        word_t d;
        // fresh result words for every pass
        result_tab.delete();
        for (int r = 0; r < result_number; r++)
            result_tab.push_back(word_t'($random(seed)));
        spike_base = got_spike.size();
        step_base  = step_seen;
        pulse_run();
        @(negedge neu_clk);
        check_bit($sformatf("pass %0d run_done cleared by run", pass), 1'b0, run_done);
        check_count($sformatf("pass %0d result_count cleared by run", pass), '0, result_count);
        fork
            wait_run_done(pass, spike_base, step_base);
            send_results();
            host_contention(pass);
        join
        // table order, and each spike inside its own step
        foreach (spike_tab[i])
        begin
            check_spike($sformatf("pass %0d spike %0d", pass, i),
                        spike_tab[i], got_spike[spike_base + i]);
            check_count($sformatf("pass %0d step of spike %0d", pass, i),
                        addr_width'(step_base + spike_step[i]),
                        addr_width'(got_step[spike_base + i]));
        end
        // last collector write may still be in flight
        n = 0;
        while (int'(result_count) != result_number && n < wait_limit)
        begin
            @(negedge neu_clk);
            n++;
        end
        check_count($sformatf("pass %0d result_count", pass),
                    addr_width'(result_number), result_count);
        foreach (result_tab[r])
        begin
            host_read(addr_width'(result_base + r), d);
            check_word($sformatf("pass %0d result word %0d", pass, r), result_tab[r], d);
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial
    begin
        word_t d;
        rst_n        = 1'b0;
        run          = 1'b0;
        host_req     = '0;
        host_valid   = 1'b0;
        result_in    = '0;
        result_valid = 1'b0;
        build_tables();
        repeat (4) @(posedge neu_clk);
        @(negedge neu_clk);
        check_bit("result_ready in reset", 1'b0, result_ready);
        @(posedge neu_clk);
        rst_n <= 1'b1;
        @(negedge neu_clk);
        check_bit("spike_valid after reset", 1'b0, spike_valid);
        check_bit("step_start after reset", 1'b0, step_start);
        check_bit("run_done after reset", 1'b0, run_done);
        // schedule image from address 0 upward
        foreach (sched_img[i])
            host_write(addr_width'(i), sched_img[i]);
        host_read(addr_width'(0), d);
        check_word("header readback", sched_img[0], d);
        host_read(addr_width'(1), d);
        check_word("spike word readback", sched_img[1], d);
        run_pass(1);
        run_pass(2);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* src.f */
rtl/mesh_pkg.sv
rtl/packet_mem.sv
rtl/mem_arbiter.sv
rtl/spike_injector.sv
rtl/result_collector.sv
rtl/mesh_controller.sv
sim/tb_mesh_controller.sv

/* run_sim.sh */
#!/bin/sh
# build and run the mesh controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_mesh_controller \
    -f src.f -Mdir obj_dir
out=$(./obj_dir/Vtb_mesh_controller || true)
echo "$out"
if echo "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
